// ==== all.f ====
hdl/uart_pkg.sv
hdl/uart_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_regs.sv
hdl/uart_top.sv
bench/uart_chk.sv
bench/uart_tb.sv

// ==== Makefile ====
# Verilator flow for the UART testbench
TOP := uart_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== bench/uart_tb.sv ====
// UART loopback testbench
`timescale 1ns/1ps
`default_nettype none

module uart_tb import uart_pkg::*; ();

  // Cycles per bit for all serial tests
  localparam baud_div_t DIV        = 16'd8;
  // Status reads before a wait gives up
  localparam int        POLL_LIMIT = 400;

  logic            clk;
  logic            rst_n;
  bus_req_t        req;
  logic [XLEN-1:0] rdata;
  logic            tx_line;
  logic            rx_line;
  logic            loop_en;
  integer          seed;
  int              errors;
  int              test_errors;
  int              tests_passed;
  int              tests_failed;
  string           test_name;
  uart_byte_t      sent [$];

  // Loopback, forced idle when disconnected
  assign rx_line = loop_en ? tx_line : 1'b1;

  uart_top #(
    .FIFO_DEPTH(4)
  ) uut (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .bus_req_i(req),
    .rdata_o  (rdata),
    .uart_rx_i(rx_line),
    .uart_tx_o(tx_line)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // Expected register words
  ////////////////////////////////////////

  function automatic logic [31:0] status_word(input logic tx_full, input logic tx_empty,
                                              input logic rx_full, input logic rx_empty);
    return {28'h0, rx_empty, rx_full, tx_empty, tx_full};
  endfunction

  function automatic logic [31:0] ctrl_word(input baud_div_t div, input logic rx_en,
                                            input logic tx_en);
    return {div, 14'h0, rx_en, tx_en};
  endfunction

  ////////////////////////////////////////
  // Bus access
  ////////////////////////////////////////

  task automatic bus_write(input reg_adr_t adr, input logic [3:0] be, input logic [31:0] data);
    @(negedge clk);
    req = '{stb: 1'b1, adr: adr, be: be, we: 1'b1, wdata: data};
    @(negedge clk);
    req = '0;
  endtask

  // Sample mid low phase, strobe stays up across the edge
  task automatic bus_read(input reg_adr_t adr, output logic [31:0] data);
    @(negedge clk);
    req = '{stb: 1'b1, adr: adr, be: 4'hF, we: 1'b0, wdata: '0};
    #5;
    data = rdata;
    @(negedge clk);
    req = '0;
  endtask

  task automatic push_byte(input uart_byte_t b);
    bus_write(ADR_TXDATA, 4'b0001, {24'h0, b});
  endtask

  task automatic random_byte(output uart_byte_t b);
    logic [31:0] r;
    r = $random(seed);
    b = r[7:0];
  endtask

  ////////////////////////////////////////
  // Checks and waits
  ////////////////////////////////////////

  task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("[ERROR] %s expected 0x%08h got 0x%08h", name, exp, got);
      errors++;
    end
  endtask

  // Poll one status bit until it reaches val
  task automatic wait_status(input int bit_idx, input logic val, input string what);
    logic [31:0] st;
    int          polls;
    polls = 0;
    bus_read(ADR_STAT, st);
    while ((st[bit_idx] !== val) && (polls < POLL_LIMIT)) begin
      polls++;
      bus_read(ADR_STAT, st);
    end
    if (st[bit_idx] !== val) begin
      $display("Timeout: %s did not happen within %0d status reads", what, POLL_LIMIT);
      errors++;
    end
  endtask

  task automatic receive_expect(input uart_byte_t exp);
    logic [31:0] rd;
    wait_status(3, 1'b0, "received byte");
    bus_read(ADR_RXDATA, rd);
    expect_equal("rx_data", {24'h0, exp}, rd);
  endtask

  // One frame plus margin for the synchronizer
  task automatic wait_frame();
    repeat (12 * DIV) @(negedge clk);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic finish_test();
    if (errors == test_errors) begin
      tests_passed++;
      $display("[PASS] %s", test_name);
    end else begin
      tests_failed++;
      $display("[FAIL] %s", test_name);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    uart_byte_t  b;
    logic [31:0] rd;
    req          = '0;
    rst_n        = 1'b0;
    loop_en      = 1'b1;
    seed         = 4656;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    start_test("reset values");
    bus_read(ADR_CTRL, rd);
    expect_equal("ctrl", 32'h0, rd);
    bus_read(ADR_STAT, rd);
    expect_equal("status", status_word(1'b0, 1'b1, 1'b0, 1'b1), rd);
    finish_test();

    // Upper bytes only touch the divisor, byte 0 only the enables
    start_test("control byte selects");
    bus_write(ADR_CTRL, 4'b1100, 32'h1234_0003);
    bus_read(ADR_CTRL, rd);
    expect_equal("ctrl", ctrl_word(16'h1234, 1'b0, 1'b0), rd);
    bus_write(ADR_CTRL, 4'b0001, 32'hABCD_0003);
    bus_read(ADR_CTRL, rd);
    expect_equal("ctrl", ctrl_word(16'h1234, 1'b1, 1'b1), rd);
    bus_write(ADR_CTRL, 4'hF, 32'h0);
    finish_test();

    start_test("loopback");
    bus_write(ADR_CTRL, 4'hF, ctrl_word(DIV, 1'b1, 1'b1));
    sent.delete();
    repeat (3) begin
      random_byte(b);
      sent.push_back(b);
      push_byte(b);
    end
    foreach (sent[i]) begin
      receive_expect(sent[i]);
    end
    wait_status(1, 1'b1, "TX FIFO empty");
    bus_read(ADR_STAT, rd);
    expect_equal("status", status_word(1'b0, 1'b1, 1'b0, 1'b1), rd);
    finish_test();

    // Fifth push lands on a full FIFO
    start_test("tx back-pressure");
    bus_write(ADR_CTRL, 4'hF, ctrl_word(DIV, 1'b1, 1'b0));
    sent.delete();
    repeat (4) begin
      random_byte(b);
      sent.push_back(b);
      push_byte(b);
    end
    bus_read(ADR_STAT, rd);
    expect_equal("status", status_word(1'b1, 1'b0, 1'b0, 1'b1), rd);
    random_byte(b);
    push_byte(b);
    bus_read(ADR_STAT, rd);
    expect_equal("status", status_word(1'b1, 1'b0, 1'b0, 1'b1), rd);
    bus_write(ADR_CTRL, 4'hF, ctrl_word(DIV, 1'b1, 1'b1));
    foreach (sent[i]) begin
      receive_expect(sent[i]);
    end
    wait_frame();
    bus_read(ADR_STAT, rd);
    expect_equal("status", status_word(1'b0, 1'b1, 1'b0, 1'b1), rd);
    finish_test();

    start_test("rx disabled");
    bus_write(ADR_CTRL, 4'hF, ctrl_word(DIV, 1'b0, 1'b1));
    random_byte(b);
    push_byte(b);
    wait_status(1, 1'b1, "TX FIFO empty");
    wait_frame();
    bus_read(ADR_STAT, rd);
    expect_equal("status", status_word(1'b0, 1'b1, 1'b0, 1'b1), rd);
    finish_test();

    // Fill TX with the line cut, then let four frames in
    start_test("rx overflow");
    loop_en = 1'b0;
    bus_write(ADR_CTRL, 4'hF, ctrl_word(DIV, 1'b1, 1'b0));
    sent.delete();
    repeat (4) begin
      random_byte(b);
      sent.push_back(b);
      push_byte(b);
    end
    loop_en = 1'b1;
    bus_write(ADR_CTRL, 4'hF, ctrl_word(DIV, 1'b1, 1'b1));
    wait_status(2, 1'b1, "RX FIFO full");
    random_byte(b);
    push_byte(b);
    wait_status(1, 1'b1, "TX FIFO empty");
    wait_frame();
    bus_read(ADR_STAT, rd);
    expect_equal("status", status_word(1'b0, 1'b1, 1'b1, 1'b0), rd);
    foreach (sent[i]) begin
      receive_expect(sent[i]);
    end
    bus_read(ADR_STAT, rd);
    expect_equal("status", status_word(1'b0, 1'b1, 1'b0, 1'b1), rd);
    finish_test();

    $display("Tests passed: %0d  failed: %0d  errors: %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/uart_chk.sv ====
// UART bound assertions
`timescale 1ns/1ps
`default_nettype none

module uart_chk import uart_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input logic      line_i,
  input logic      tx_en_i,
  input tx_state_e tx_state_i,
  input logic      tx_pop_i,
  input logic      tx_full_i,
  input logic      tx_empty_i,
  input logic      rx_full_i,
  input logic      rx_empty_i
);

  ////////////////////////////////////////
  // Line level
  ////////////////////////////////////////

  // Reset drives the line to idle
  line_high_after_reset: assert property (@(posedge clk_i) !rst_ni |=> line_i)
    else $error("TX line not idle after a reset cycle");

  // Disabled and idle transmitter keeps the line high
  line_high_when_idle: assert property (@(posedge clk_i)
    (rst_ni && !tx_en_i && (tx_state_i == TX_IDLE)) |-> line_i)
    else $error("TX line low while transmitter disabled and idle");

  ////////////////////////////////////////
  // FIFO flags
  ////////////////////////////////////////

  tx_flags_exclusive: assert property (@(posedge clk_i) rst_ni |-> !(tx_full_i && tx_empty_i))
    else $error("TX FIFO full and empty at once");

  rx_flags_exclusive: assert property (@(posedge clk_i) rst_ni |-> !(rx_full_i && rx_empty_i))
    else $error("RX FIFO full and empty at once");

  // A push that slips into a full FIFO moves the write pointer and drops full
  no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (tx_full_i && !tx_pop_i) |=> tx_full_i)
    else $error("Push into full TX FIFO");

endmodule

bind uart_top uart_chk u_chk (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .line_i    (uart_tx_o),
  .tx_en_i   (tx_en),
  .tx_state_i(u_tx.state_q),
  .tx_pop_i  (u_tx.pop),
  .tx_full_i (tx_full),
  .tx_empty_i(tx_empty),
  .rx_full_i (rx_full),
  .rx_empty_i(rx_empty)
);

`default_nettype wire

// ==== hdl/uart_top.sv ====
// UART peripheral top
`timescale 1ns/1ps
`default_nettype none

module uart_top import uart_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  bus_req_t        bus_req_i,
  output logic [XLEN-1:0] rdata_o,
  input  logic            uart_rx_i,
  output logic            uart_tx_o
);

  // Control outputs of the register block
  baud_div_t  baud_div;
  logic       tx_en;
  logic       rx_en;
  logic       tx_push;
  uart_byte_t tx_data;
  logic       rx_pop;
  // Flags and data back from the datapaths
  logic       tx_full;
  logic       tx_empty;
  uart_byte_t rx_data;
  logic       rx_full;
  logic       rx_empty;

  uart_regs u_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (bus_req_i),
    .tx_full_i (tx_full),
    .tx_empty_i(tx_empty),
    .rx_full_i (rx_full),
    .rx_empty_i(rx_empty),
    .rx_data_i (rx_data),
    .rdata_o   (rdata_o),
    .baud_div_o(baud_div),
    .tx_en_o   (tx_en),
    .rx_en_o   (rx_en),
    .tx_push_o (tx_push),
    .tx_data_o (tx_data),
    .rx_pop_o  (rx_pop)
  );

  uart_tx #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_tx (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .baud_div_i(baud_div),
    .tx_en_i   (tx_en),
    .push_i    (tx_push),
    .data_i    (tx_data),
    .full_o    (tx_full),
    .empty_o   (tx_empty),
    .tx_o      (uart_tx_o)
  );

  uart_rx #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_rx (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .baud_div_i(baud_div),
    .rx_en_i   (rx_en),
    .rx_i      (uart_rx_i),
    .pop_i     (rx_pop),
    .data_o    (rx_data),
    .full_o    (rx_full),
    .empty_o   (rx_empty)
  );

endmodule

`default_nettype wire

// ==== hdl/uart_regs.sv ====
// UART register block
`timescale 1ns/1ps
`default_nettype none

module uart_regs import uart_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  bus_req_t        req_i,
  input  logic            tx_full_i,
  input  logic            tx_empty_i,
  input  logic            rx_full_i,
  input  logic            rx_empty_i,
  input  uart_byte_t      rx_data_i,
  output logic [XLEN-1:0] rdata_o,
  output baud_div_t       baud_div_o,
  output logic            tx_en_o,
  output logic            rx_en_o,
  output logic            tx_push_o,
  output uart_byte_t      tx_data_o,
  output logic            rx_pop_o
);

  logic            ctrl_wr;
  logic [XLEN-1:0] status;

  ////////////////////////////////////////
  // Control register
  ////////////////////////////////////////

  assign ctrl_wr = req_i.stb && req_i.we && (req_i.adr == ADR_CTRL);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      tx_en_o    <= 1'b0;
      rx_en_o    <= 1'b0;
      baud_div_o <= '0;
    end else if (ctrl_wr) begin
      // Enables in byte 0
      if (req_i.be[0]) begin
        tx_en_o <= req_i.wdata[0];
        rx_en_o <= req_i.wdata[1];
      end
      // Divisor needs both upper bytes
      if (&req_i.be[3:2]) begin
        baud_div_o <= req_i.wdata[31:16];
      end
    end
  end

  ////////////////////////////////////////
  // Read mux and FIFO strobes
  ////////////////////////////////////////

  assign status = {{(XLEN-4){1'b0}}, rx_empty_i, rx_full_i, tx_empty_i, tx_full_i};

  always_comb begin
    rdata_o = '0;
    case (req_i.adr)
      ADR_CTRL:   rdata_o = {baud_div_o, {(XLEN-18){1'b0}}, rx_en_o, tx_en_o};
      ADR_STAT:   rdata_o = status;
      ADR_RXDATA: rdata_o = {{(XLEN-8){1'b0}}, rx_data_i};
      // Data address reads back status
      ADR_TXDATA: rdata_o = status;
      default:    rdata_o = '0;
    endcase
  end

  // Full and empty are only tested here
  assign tx_push_o = req_i.stb && req_i.we && (req_i.adr == ADR_TXDATA) &&
                     req_i.be[0] && !tx_full_i;
  assign rx_pop_o  = req_i.stb && (req_i.adr == ADR_RXDATA) &&
                     req_i.be[0] && !rx_empty_i;
  assign tx_data_o = req_i.wdata[7:0];

endmodule

`default_nettype wire

// ==== hdl/uart_rx.sv ====
// UART receiver
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  baud_div_t  baud_div_i,
  input  logic       rx_en_i,
  input  logic       rx_i,
  input  logic       pop_i,
  output uart_byte_t data_o,
  output logic       full_o,
  output logic       empty_o
);

  logic       rx_meta_q;
  logic       rx_sync_q;
  rx_state_e  state_q;
  baud_div_t  baud_cnt_q;
  logic [2:0] bit_cnt_q;
  uart_byte_t shift_q;
  logic       half_end;
  logic       bit_end;
  logic       push;

  ////////////////////////////////////////
  // Line synchronizer
  ////////////////////////////////////////

  // Two flops, idle high out of reset
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  // Middle of the start bit
  assign half_end = (baud_cnt_q == (baud_div_i >> 1));
  // One full bit from the last sample
  assign bit_end  = (baud_cnt_q == baud_div_i - 1'b1);

  // Good stop bit, enabled, room in the queue
  assign push = (state_q == RX_STOP) && bit_end && rx_sync_q &&
                rx_en_i && !full_o;

  ////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= RX_IDLE;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else begin
      case (state_q)
        RX_IDLE: begin
          baud_cnt_q <= '0;
          // Line dropped out of idle
          if (!rx_sync_q) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (half_end) begin
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            // High again at mid bit means a glitch
            state_q    <= rx_sync_q ? RX_IDLE : RX_DATA;
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            baud_cnt_q <= '0;
            bit_cnt_q  <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            // Bad stop bit drops the byte too
            baud_cnt_q <= '0;
            state_q    <= RX_IDLE;
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk_i) begin
    if ((state_q == RX_DATA) && bit_end) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  uart_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (push),
    .pop_i  (pop_i),
    .data_i (shift_q),
    .data_o (data_o),
    .full_o (full_o),
    .empty_o(empty_o)
  );

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
// UART transmitter
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  baud_div_t  baud_div_i,
  input  logic       tx_en_i,
  input  logic       push_i,
  input  uart_byte_t data_i,
  output logic       full_o,
  output logic       empty_o,
  output logic       tx_o
);

  tx_state_e  state_q;
  baud_div_t  baud_cnt_q;
  logic [2:0] bit_cnt_q;
  uart_byte_t shift_q;
  uart_byte_t head;
  logic       bit_end;
  logic       pop;
  logic       shift;

  // Byte queue in front of the serializer
  uart_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (push_i),
    .pop_i  (pop),
    .data_i (data_i),
    .data_o (head),
    .full_o (full_o),
    .empty_o(empty_o)
  );

  // Last cycle of the current bit
  assign bit_end = (baud_cnt_q == baud_div_i - 1'b1);

  // Start a frame from idle, or back to back after a stop bit
  assign pop = tx_en_i && !empty_o &&
               ((state_q == TX_IDLE) || ((state_q == TX_STOP) && bit_end));

  // Advance to the next data bit
  assign shift = bit_end &&
                 ((state_q == TX_START) || ((state_q == TX_DATA) && (bit_cnt_q != 3'd7)));

  ////////////////////////////////////////
  // Frame FSM and line register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= TX_IDLE;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      tx_o       <= 1'b1;
    end else if (pop) begin
      // Start bit goes out with the pop
      state_q    <= TX_START;
      baud_cnt_q <= '0;
      tx_o       <= 1'b0;
    end else begin
      baud_cnt_q <= bit_end ? '0 : baud_cnt_q + 1'b1;
      case (state_q)
        TX_IDLE: begin
          baud_cnt_q <= '0;
          tx_o       <= 1'b1;
        end
        TX_START: begin
          if (bit_end) begin
            state_q   <= TX_DATA;
            bit_cnt_q <= '0;
            tx_o      <= shift_q[0];
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= TX_STOP;
              tx_o    <= 1'b1;
            end else begin
              tx_o    <= shift_q[0];
            end
          end
        end
        TX_STOP: begin
          if (bit_end) begin
            state_q <= TX_IDLE;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // Data shifter, LSB first
  always_ff @(posedge clk_i) begin
    if (pop) begin
      shift_q <= head;
    end else if (shift) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

endmodule

`default_nettype wire

// ==== hdl/uart_fifo.sv ====
// Byte FIFO
`timescale 1ns/1ps
`default_nettype none

module uart_fifo import uart_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       push_i,
  input  logic       pop_i,
  input  uart_byte_t data_i,
  output uart_byte_t data_o,
  output logic       full_o,
  output logic       empty_o
);

  // Index width, pointers carry one extra wrap bit
  localparam int unsigned AW = $clog2(FIFO_DEPTH);

  uart_byte_t     mem [FIFO_DEPTH];
  logic [AW:0]    wr_ptr_q;
  logic [AW:0]    rd_ptr_q;

  ////////////////////////////////////////
  // Pointers
  ////////////////////////////////////////

  // Caller guarantees no push when full and no pop when empty
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q[AW-1:0]] <= data_i;
    end
  end

  // Head shows without a pop
  assign data_o  = mem[rd_ptr_q[AW-1:0]];

  // Same index, wrap bits differ when full
  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                   (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

endmodule

`default_nettype wire

// ==== hdl/uart_pkg.sv ====
// UART shared definitions
`default_nettype none

package uart_pkg;

  ////////////////////////////////////////
  // Bus and register map
  ////////////////////////////////////////

  // Data bus width of the attached core
  localparam int unsigned XLEN = 32;

  // Clock cycles per serial bit
  typedef logic [15:0] baud_div_t;
  // One line byte
  typedef logic [7:0]  uart_byte_t;
  // Word address within the peripheral
  typedef logic [1:0]  reg_adr_t;

  localparam reg_adr_t ADR_CTRL   = 2'd0;
  localparam reg_adr_t ADR_STAT   = 2'd1;
  localparam reg_adr_t ADR_RXDATA = 2'd2;
  localparam reg_adr_t ADR_TXDATA = 2'd3;

  // Single-cycle strobe request from the core
  typedef struct packed {
    logic            stb;
    reg_adr_t        adr;
    logic [3:0]      be;
    logic            we;
    logic [XLEN-1:0] wdata;
  } bus_req_t;

  ////////////////////////////////////////
  // Serializer states
  ////////////////////////////////////////

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

`default_nettype wire
